/* src/rtc_edit_pkg.sv */
package rtc_edit_pkg;

	////////////////////
	// modes and states
	////////////////////

	typedef enum logic [1:0]
	{
		MODE_RUN,
		MODE_TIME,
		MODE_ALARM,
		MODE_TIMER
	} edit_mode_e;

	typedef enum logic [2:0]
	{
		SEQ_IDLE,
		SEQ_READ,
		SEQ_CALC,
		SEQ_WRITE,
		SEQ_DONE
	} seq_state_e;

	////////////////////
	// field layout
	////////////////////

	localparam int FIELD_COUNT = 13;
	localparam int FIELD_W = 4;
	localparam int DATA_W = 8;
	localparam int ADDR_W = 8;

	// group bounds as field indices
	localparam logic [FIELD_W-1:0] TIME_FIRST = 4'd0;
	localparam logic [FIELD_W-1:0] TIME_LAST = 4'd5;
	localparam logic [FIELD_W-1:0] ALARM_FIRST = 4'd6;
	localparam logic [FIELD_W-1:0] ALARM_LAST = 4'd9;
	localparam logic [FIELD_W-1:0] TIMER_FIRST = 4'd10;
	localparam logic [FIELD_W-1:0] TIMER_LAST = 4'd12;

	// clock chip register per field
	localparam logic [ADDR_W-1:0] FIELD_ADDR [FIELD_COUNT] = '{
		8'h20, 8'h21, 8'h22, 8'h23, 8'h24, 8'h26,
		8'h31, 8'h32, 8'h33, 8'h34,
		8'h41, 8'h42, 8'h43
	};

	function automatic logic [FIELD_W-1:0] group_first_of(edit_mode_e mode);
		case (mode)
			MODE_TIME: return TIME_FIRST;
			MODE_ALARM: return ALARM_FIRST;
			MODE_TIMER: return TIMER_FIRST;
			default: return '0;
		endcase
	endfunction

	function automatic logic [FIELD_W-1:0] group_last_of(edit_mode_e mode);
		case (mode)
			MODE_TIME: return TIME_LAST;
			MODE_ALARM: return ALARM_LAST;
			MODE_TIMER: return TIMER_LAST;
			default: return '0;
		endcase
	endfunction

endpackage

/* src/button_decode.sv */
module button_decode
	import rtc_edit_pkg::*;
(
	input  logic               CLK,
	input  logic               reset,
	input  edit_mode_e         mode,
	input  logic               btn_left,
	input  logic               btn_right,
	input  logic               btn_up,
	input  logic               btn_down,
	input  logic               commit,
	input  logic               busy,
	output logic               step_up,
	output logic               step_down,
	output logic               start,
	output logic [FIELD_W-1:0] cursor,
	output logic [FIELD_W-1:0] group_first,
	output logic [FIELD_W-1:0] group_last
);

	logic [4:0] btn_q;
	logic [4:0] btn_prev;
	logic       left_rise;
	logic       right_rise;
	logic       up_rise;
	logic       down_rise;
	logic       commit_rise;
	edit_mode_e mode_q;
	edit_mode_e mode_prev;
	logic       mode_chg;
	logic       left_p;
	logic       right_p;
	logic       accept;

	// sample buttons and mode once
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			btn_q <= '0;
			btn_prev <= '0;
			mode_q <= MODE_RUN;
			mode_prev <= MODE_RUN;
		end
		else
		begin
			btn_q <= {commit, btn_down, btn_up, btn_right, btn_left};
			btn_prev <= btn_q;
			mode_q <= mode;
			mode_prev <= mode_q;
		end
	end

	assign {commit_rise, down_rise, up_rise, right_rise, left_rise} = btn_q & ~btn_prev;

	// nothing gets through in run mode or during a commit
	assign accept = (mode_q != MODE_RUN) && !busy;

	assign group_first = group_first_of(mode_q);
	assign group_last = group_last_of(mode_q);

	////////////////////
	// registered pulses
	////////////////////

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			left_p <= 1'b0;
			right_p <= 1'b0;
			step_up <= 1'b0;
			step_down <= 1'b0;
			start <= 1'b0;
			mode_chg <= 1'b0;
		end
		else
		begin
			left_p <= left_rise && accept;
			right_p <= right_rise && accept;
			step_up <= up_rise && accept;
			step_down <= down_rise && accept;
			start <= commit_rise && accept;
			mode_chg <= (mode_q != mode_prev);
		end
	end

	// cursor, saturating at the group bounds
	always_ff @(posedge CLK)
	begin
		if (reset)
			cursor <= '0;
		else if (mode_chg)
			cursor <= group_first;
		else if (left_p && cursor > group_first)
			cursor <= cursor - 1'b1;
		else if (right_p && cursor < group_last)
			cursor <= cursor + 1'b1;
	end

	// once the mode has settled, the cursor sits in its group
	property p_cursor_in_group;
		@(posedge CLK) disable iff (reset)
		(!mode_chg && mode_q == mode_prev && mode_q != MODE_RUN)
			|-> (cursor >= group_first && cursor <= group_last);
	endproperty
	a_cursor_in_group : assert property (p_cursor_in_group);

endmodule

/* src/field_adjust.sv */
module field_adjust
	import rtc_edit_pkg::*;
(
	input  logic               CLK,
	input  logic               reset,
	input  logic               step_up,
	input  logic               step_down,
	input  logic [FIELD_W-1:0] cursor,
	input  logic               clear_en,
	input  logic [FIELD_W-1:0] clear_field,
	input  logic [FIELD_W-1:0] seq_field,
	output logic [DATA_W-1:0]  seq_adjust
);

	logic [DATA_W-1:0] adj [FIELD_COUNT];
	logic              cursor_ok;
	logic              clear_ok;

	assign cursor_ok = (cursor < FIELD_COUNT);
	assign clear_ok = (clear_field < FIELD_COUNT);

	////////////////////
	// adjustment bank
	////////////////////

	// counters wrap, so down from zero gives 255
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < FIELD_COUNT; i++)
			begin
				adj[i] <= '0;
			end
		end
		else
		begin
			if (step_up && cursor_ok)
				adj[cursor] <= adj[cursor] + 1'b1;
			else if (step_down && cursor_ok)
				adj[cursor] <= adj[cursor] - 1'b1;

			// clear comes last and wins on the same field
			if (clear_en && clear_ok)
				adj[clear_field] <= '0;
		end
	end

	// sequencer side read port
	assign seq_adjust = (seq_field < FIELD_COUNT) ? adj[seq_field] : '0;

	// the decoder never steps both ways at once
	a_step_exclusive : assert property (
		@(posedge CLK) disable iff (reset)
		!(step_up && step_down)
	);

endmodule

/* src/commit_sequencer.sv */
module commit_sequencer
	import rtc_edit_pkg::*;
(
	input  logic               CLK,
	input  logic               reset,
	input  logic               start,
	input  logic [FIELD_W-1:0] group_first,
	input  logic [FIELD_W-1:0] group_last,
	input  logic [DATA_W-1:0]  seq_adjust,
	input  logic [DATA_W-1:0]  wb_dat_r,
	input  logic               wb_ack,
	output logic [FIELD_W-1:0] seq_field,
	output logic               clear_en,
	output logic [FIELD_W-1:0] clear_field,
	output logic               busy,
	output logic               done,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output logic [ADDR_W-1:0]  wb_adr,
	output logic [DATA_W-1:0]  wb_dat_w
);

	seq_state_e         state;
	logic [FIELD_W-1:0] last_field;
	logic [DATA_W-1:0]  rd_data;
	logic               bus_ack;
	logic               launch;

	assign bus_ack = wb_cyc && wb_stb && wb_ack;
	assign launch = (state == SEQ_IDLE || state == SEQ_DONE) && start;

	assign busy = (state != SEQ_IDLE) && (state != SEQ_DONE);
	assign done = (state == SEQ_DONE);

	// field is cleared on the edge that completes its write
	assign clear_en = (state == SEQ_WRITE) && bus_ack;
	assign clear_field = seq_field;

	////////////////////
	// walk state machine
	////////////////////

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			seq_field <= '0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end
		else
		begin
			case (state)
				SEQ_IDLE, SEQ_DONE:
				begin
					if (launch)
					begin
						seq_field <= group_first;
						state <= SEQ_READ;
					end
					else
						state <= SEQ_IDLE;
				end
				SEQ_READ:
				begin
					if (!wb_cyc)
					begin
						// address loads as the read opens
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= 1'b0;
					end
					else if (bus_ack)
					begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						state <= SEQ_CALC;
					end
				end
				SEQ_CALC:
				begin
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we <= 1'b1;
					state <= SEQ_WRITE;
				end
				SEQ_WRITE:
				begin
					if (bus_ack)
					begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						if (seq_field == last_field)
							state <= SEQ_DONE;
						else
						begin
							seq_field <= seq_field + 1'b1;
							state <= SEQ_READ;
						end
					end
				end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

	// address, read data and write data
	always_ff @(posedge CLK)
	begin
		if (launch)
			last_field <= group_last;
		if (state == SEQ_READ && !wb_cyc)
			wb_adr <= FIELD_ADDR[seq_field];
		if (state == SEQ_READ && bus_ack)
			rd_data <= wb_dat_r;
		if (state == SEQ_CALC)
			wb_dat_w <= rd_data + seq_adjust;
	end

	a_stb_in_cyc : assert property (
		@(posedge CLK) disable iff (reset)
		wb_stb |-> wb_cyc
	);

	// a stalled transfer keeps its request steady
	property p_bus_hold;
		@(posedge CLK) disable iff (reset)
		(wb_stb && !wb_ack) |=>
			(wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w));
	endproperty
	a_bus_hold : assert property (p_bus_hold);

endmodule

/* src/rtc_edit_top.sv */
module rtc_edit_top
	import rtc_edit_pkg::*;
(
	input  logic               CLK,
	input  logic               reset,
	input  edit_mode_e         mode,
	input  logic               btn_left,
	input  logic               btn_right,
	input  logic               btn_up,
	input  logic               btn_down,
	input  logic               commit,
	input  logic [DATA_W-1:0]  wb_dat_r,
	input  logic               wb_ack,
	output logic [FIELD_W-1:0] cursor,
	output logic               busy,
	output logic               done,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output logic [ADDR_W-1:0]  wb_adr,
	output logic [DATA_W-1:0]  wb_dat_w
);

	logic               step_up;
	logic               step_down;
	logic               start;
	logic [FIELD_W-1:0] group_first;
	logic [FIELD_W-1:0] group_last;
	logic [FIELD_W-1:0] seq_field;
	logic [DATA_W-1:0]  seq_adjust;
	logic               clear_en;
	logic [FIELD_W-1:0] clear_field;

	// buttons, mode and cursor
	button_decode u_button_decode (
		.CLK         (CLK),
		.reset       (reset),
		.mode        (mode),
		.btn_left    (btn_left),
		.btn_right   (btn_right),
		.btn_up      (btn_up),
		.btn_down    (btn_down),
		.commit      (commit),
		.busy        (busy),
		.step_up     (step_up),
		.step_down   (step_down),
		.start       (start),
		.cursor      (cursor),
		.group_first (group_first),
		.group_last  (group_last)
	);

	field_adjust u_field_adjust (
		.CLK         (CLK),
		.reset       (reset),
		.step_up     (step_up),
		.step_down   (step_down),
		.cursor      (cursor),
		.clear_en    (clear_en),
		.clear_field (clear_field),
		.seq_field   (seq_field),
		.seq_adjust  (seq_adjust)
	);

	// read-modify-write over the bus
	commit_sequencer u_commit_sequencer (
		.CLK         (CLK),
		.reset       (reset),
		.start       (start),
		.group_first (group_first),
		.group_last  (group_last),
		.seq_adjust  (seq_adjust),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.seq_field   (seq_field),
		.clear_en    (clear_en),
		.clear_field (clear_field),
		.busy        (busy),
		.done        (done),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w)
	);

endmodule

/* sim/tb_rtc_edit.sv */
module tb_rtc_edit
	import rtc_edit_pkg::*;
();

	logic               CLK;
	logic               reset;
	edit_mode_e         mode;
	logic               btn_left;
	logic               btn_right;
	logic               btn_up;
	logic               btn_down;
	logic               commit;
	logic [DATA_W-1:0]  wb_dat_r;
	logic               wb_ack;
	logic [FIELD_W-1:0] cursor;
	logic               busy;
	logic               done;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	logic [ADDR_W-1:0]  wb_adr;
	logic [DATA_W-1:0]  wb_dat_w;

	integer            seed;
	logic [DATA_W-1:0] mem [256];
	logic [DATA_W-1:0] shadow [256];
	logic [DATA_W-1:0] model_adj [FIELD_COUNT];
	logic [ADDR_W-1:0] exp_addr [$];
	int                model_cursor;
	int                in_xfer;
	int                wait_left;
	int                errors;
	int                bus_errs;
	int                commits;
	int                tests_ok;
	int                tests_bad;
	int                mark;

	rtc_edit_top u_rtc_edit_top (
		.CLK       (CLK),
		.reset     (reset),
		.mode      (mode),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_up    (btn_up),
		.btn_down  (btn_down),
		.commit    (commit),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.cursor    (cursor),
		.busy      (busy),
		.done      (done),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w)
	);

	always #4 CLK = ~CLK;

	////////////////////
	// reference helpers
	////////////////////

	function automatic int first_field(input edit_mode_e m);
		case (m)
			MODE_TIME: return 0;
			MODE_ALARM: return 6;
			MODE_TIMER: return 10;
			default: return 0;
		endcase
	endfunction

	function automatic int last_field(input edit_mode_e m);
		case (m)
			MODE_TIME: return 5;
			MODE_ALARM: return 9;
			MODE_TIMER: return 12;
			default: return 0;
		endcase
	endfunction

	function automatic int field_of(input logic [ADDR_W-1:0] a);
		for (int i = 0; i < FIELD_COUNT; i++)
		begin
			if (FIELD_ADDR[i] == a)
				return i;
		end
		return 0;
	endfunction

	task automatic check_eq(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic step_cycle();
		@(posedge CLK);
		#1;
	endtask

	////////////////////
	// wishbone slave
	////////////////////

	task automatic finish_transfer();
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] expv;
		int                f;
		assert (exp_addr.size() != 0)
		else
		begin
			$display("bus cycle to address %h at %0t with no commit pending", wb_adr, $time);
			errors++;
		end
		if (exp_addr.size() != 0 && !wb_we)
			check_eq("wb_adr", wb_adr, exp_addr[0]);
		else if (exp_addr.size() != 0)
		begin
			a = exp_addr.pop_front();
			f = field_of(a);
			expv = shadow[a] + model_adj[f];
			check_eq("wb_adr", wb_adr, a);
			check_eq("wb_dat_w", wb_dat_w, expv);
			mem[wb_adr] = wb_dat_w;
			shadow[a] = expv;
			model_adj[f] = '0;
		end
	endtask

	// ack after 0 to 5 wait cycles
	always @(posedge CLK)
	begin
		if (wb_cyc && wb_stb && wb_ack)
		begin
			finish_transfer();
			#1;
			wb_ack = 1'b0;
			in_xfer = 0;
		end
		else if (wb_cyc && wb_stb)
		begin
			if (in_xfer == 0)
			begin
				in_xfer = 1;
				wait_left = $unsigned($random(seed)) % 6;
			end
			if (wait_left == 0)
			begin
				#1;
				wb_dat_r = mem[wb_adr];
				wb_ack = 1'b1;
			end
			else
				wait_left--;
		end
	end

	// request held while the slave stalls
	a_req_hold : assert property (@(posedge CLK) disable iff (reset)
		(wb_stb && !wb_ack) |=>
			($stable(wb_adr) && $stable(wb_we) && (!wb_we || $stable(wb_dat_w))))
	else
	begin
		$display("bus request changed at %0t while ack was held off", $time);
		bus_errs++;
	end

	a_busy_with_done : assert property (@(posedge CLK) disable iff (reset)
		$fell(busy) |-> done)
	else
	begin
		$display("busy fell without done at %0t", $time);
		bus_errs++;
	end

	a_done_not_busy : assert property (@(posedge CLK) disable iff (reset)
		done |-> !busy)
	else
	begin
		$display("done and busy high together at %0t", $time);
		bus_errs++;
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic set_button(input int which, input logic v);
		case (which)
			0: btn_left = v;
			1: btn_right = v;
			2: btn_up = v;
			3: btn_down = v;
			default: commit = v;
		endcase
	endtask

	// 0 left, 1 right, 2 up, 3 down, 4 commit
	task automatic press(input int which);
		set_button(which, 1'b1);
		repeat (3) step_cycle();
		set_button(which, 1'b0);
		repeat (3) step_cycle();
		if (mode != MODE_RUN)
		begin
			if (which == 0 && model_cursor > first_field(mode))
				model_cursor--;
			else if (which == 1 && model_cursor < last_field(mode))
				model_cursor++;
			else if (which == 2)
				model_adj[model_cursor]++;
			else if (which == 3)
				model_adj[model_cursor]--;
		end
		check_eq("cursor", cursor, model_cursor);
	endtask

	task automatic set_mode(input edit_mode_e m);
		mode = m;
		repeat (5) step_cycle();
		model_cursor = first_field(m);
		check_eq("cursor", cursor, model_cursor);
	endtask

	task automatic commit_group();
		int n;
		for (int f = first_field(mode); f <= last_field(mode); f++)
			exp_addr.push_back(FIELD_ADDR[f]);
		set_button(4, 1'b1);
		repeat (3) step_cycle();
		set_button(4, 1'b0);
		n = 0;
		while (!done && n < 200)
		begin
			step_cycle();
			n++;
		end
		if (!done)
		begin
			$display("timeout at %0t: commit gave no done within 200 cycles", $time);
			$display("Test failed");
			$finish;
		end
		else
		begin
			commits++;
			repeat (2) step_cycle();
			assert (exp_addr.size() == 0)
			else
			begin
				$display("commit ended at %0t with %0d writes missing", $time, exp_addr.size());
				errors++;
			end
			exp_addr.delete();
		end
	endtask

	task automatic report(input string name);
		if (errors == mark)
		begin
			tests_ok++;
			$display("%s: ok", name);
		end
		else
		begin
			tests_bad++;
			$display("%s: FAIL with %0d errors", name, errors - mark);
		end
		mark = errors;
	endtask

	initial
	begin
		CLK = 1'b0;
		reset = 1'b1;
		mode = MODE_RUN;
		btn_left = 1'b0;
		btn_right = 1'b0;
		btn_up = 1'b0;
		btn_down = 1'b0;
		commit = 1'b0;
		wb_dat_r = '0;
		wb_ack = 1'b0;
		seed = 44859;
		errors = 0;
		bus_errs = 0;
		commits = 0;
		tests_ok = 0;
		tests_bad = 0;
		mark = 0;
		in_xfer = 0;
		wait_left = 0;
		model_cursor = 0;
		for (int i = 0; i < 256; i++)
		begin
			mem[i] = $random(seed);
			shadow[i] = mem[i];
		end
		for (int i = 0; i < FIELD_COUNT; i++)
			model_adj[i] = '0;
		repeat (4) @(posedge CLK);
		#1;
		reset = 1'b0;

		// run mode ignores everything
		check_eq("wb_cyc", wb_cyc, 0);
		check_eq("wb_stb", wb_stb, 0);
		check_eq("busy", busy, 0);
		check_eq("done", done, 0);
		check_eq("cursor", cursor, 0);
		for (int b = 0; b < 5; b++)
			press(b);
		repeat (10) step_cycle();
		report("test 1 reset and run mode");

		set_mode(MODE_TIME);
		press(1);
		press(1);
		repeat (3) press(2);
		commit_group();
		report("test 2 time edit");

		// saturate at both ends, then wrap below zero
		set_mode(MODE_ALARM);
		repeat (4) press(0);
		repeat (6) press(1);
		press(3);
		commit_group();
		report("test 3 cursor bounds and wrap");

		set_mode(MODE_TIMER);
		press(2);
		press(2);
		press(1);
		press(3);
		press(1);
		press(2);
		set_mode(MODE_TIME);
		commit_group();
		set_mode(MODE_TIMER);
		commit_group();
		commit_group();
		report("test 4 group isolation and clearing");

		if (bus_errs == 0 && commits == 5)
		begin
			tests_ok++;
			$display("test 5 back-pressure: ok");
		end
		else
		begin
			tests_bad++;
			$display("test 5 back-pressure: FAIL, %0d bus errors, %0d commits", bus_errs, commits);
		end

		$display("summary: %0d ok, %0d failing", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* flist.f */
src/rtc_edit_pkg.sv
src/button_decode.sv
src/field_adjust.sv
src/commit_sequencer.sv
src/rtc_edit_top.sv
sim/tb_rtc_edit.sv
